// ==== hdl/fetch_defines.svh ====
// fetch front end shared constants
// widths, encodings and sizing for the rv_fetch blocks

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// address and data word width
`define XLEN 32

// addi x0, x0, 0
`define NOP 32'h0000_0013

// instruction buffer depth, kept a power of two
`define INST_BUF_SIZE 8

// cycles an address must be held before line data is good
`define IMEM_LATENCY 2

// 64-bit lines in the instruction memory, 256 bytes total
`define IMEM_LINES 32

`endif

// ==== hdl/fetch_pkg.sv ====
// fetch front end types
// vector typedefs for addresses, instructions, memory lines
// and buffer pointers, plus the fetch FSM states

`include "fetch_defines.svh"

package fetch_pkg;

    // program counter and any byte address
    typedef logic [`XLEN-1:0] addr_t;

    // one 32-bit instruction word
    typedef logic [31:0] inst_t;

    // one instruction memory line, two words
    typedef logic [63:0] line_t;

    // buffer pointer with one extra wrap bit, also wide enough for the count
    typedef logic [$clog2(`INST_BUF_SIZE):0] buf_idx_t;

    // ISSUE picks the next pc, WAIT holds it until memory answers
    typedef enum logic {
        ISSUE,
        WAIT
    } fetch_state_t;

endpackage

// ==== hdl/pc_source_arbiter.sv ====
// next pc arbiter
// fixed priority over execute branch, ROB target, predictor and pc+4

`timescale 1ns/1ps

module pc_source_arbiter
    import fetch_pkg::*;
(
    input  logic       certain_branch_req,
    input  addr_t      certain_branch_pc,
    input  logic       rob_target_req,
    input  addr_t      rob_target_pc,
    input  logic       branch_pred_req,
    input  addr_t      branch_pred_pc,
    input  addr_t      pc,
    output logic [3:0] grant,
    output addr_t      next_pc
);

    // sequential source is always requesting
    addr_t seq_pc;

    assign seq_pc = pc + addr_t'(4);

    always_comb begin
        if (certain_branch_req) begin
            grant   = 4'b1000;
            next_pc = certain_branch_pc;
        end else if (rob_target_req) begin
            grant   = 4'b0100;
            next_pc = rob_target_pc;
        end else if (branch_pred_req) begin
            grant   = 4'b0010;
            next_pc = branch_pred_pc;
        end else begin
            grant   = 4'b0001;
            next_pc = seq_pc;
        end
    end

endmodule

// ==== hdl/ifetch_basic.sv ====
// instruction fetch FSM
// holds the pc, waits for the memory line, picks the addressed word
// and emits one fetch packet per completed fetch; a resolved branch
// redirects the fetch and raises squash for the instruction buffer

`timescale 1ns/1ps

`include "fetch_defines.svh"

module ifetch_basic
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  full,
    input  logic  certain_branch_req,
    input  addr_t certain_branch_pc,
    input  addr_t next_pc,
    input  line_t imem_data,
    input  logic  imem_data_valid,
    output addr_t pc,
    output addr_t imem_addr,
    output logic  packet_valid,
    output inst_t packet_inst,
    output addr_t packet_pc,
    output addr_t packet_npc,
    output logic  squash
);

    fetch_state_t state;
    // pc still needs fetching as is, true only right after reset
    logic pc_pending;
    logic fetch_done;
    inst_t fetched_word;

    // memory is line addressed, bit 2 picks the half
    assign imem_addr    = {pc[`XLEN-1:2], 2'b00};
    assign fetched_word = pc[2] ? imem_data[63:32] : imem_data[31:0];

    // a resolved branch beats returning data
    assign fetch_done = (state == WAIT) && !certain_branch_req && imem_data_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ISSUE;
            pc         <= '0;
            pc_pending <= 1'b1;
        end else begin
            unique case (state)
                ISSUE: begin
                    // full shows the packet written this cycle only one cycle later
                    // a branch still redirects when full, squash will drain the buffer
                    if (certain_branch_req || (!full && !packet_valid)) begin
                        state      <= WAIT;
                        pc_pending <= 1'b0;
                        if (certain_branch_req || !pc_pending) begin
                            pc <= next_pc;
                        end
                    end
                end
                WAIT: begin
                    if (certain_branch_req) begin
                        pc <= certain_branch_pc;
                    end else if (imem_data_valid) begin
                        state <= ISSUE;
                    end
                end
                default: begin
                    state <= ISSUE;
                end
            endcase
        end
    end

    // control strobes
    always_ff @(posedge clock) begin
        if (reset) begin
            packet_valid <= 1'b0;
            squash       <= 1'b0;
        end else begin
            packet_valid <= fetch_done;
            squash       <= certain_branch_req;
        end
    end

    // packet payload, NOP when nothing was fetched
    always_ff @(posedge clock) begin
        packet_inst <= fetch_done ? fetched_word : `NOP;
        packet_pc   <= pc;
        packet_npc  <= pc + addr_t'(4);
    end

endmodule

// ==== hdl/inst_buffer.sv ====
// instruction buffer
// circular FIFO of fetch packets between fetch and decode,
// with same-cycle push and pop and a squash that empties it

`timescale 1ns/1ps

`include "fetch_defines.svh"

module inst_buffer
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  squash,
    input  logic  packet_valid,
    input  inst_t packet_inst,
    input  addr_t packet_pc,
    input  addr_t packet_npc,
    input  logic  dec_ready,
    output logic  full,
    output logic  dec_valid,
    output inst_t dec_inst,
    output addr_t dec_pc,
    output addr_t dec_npc
);

    localparam int IDX_W = $clog2(`INST_BUF_SIZE);

    inst_t inst_q [`INST_BUF_SIZE];
    addr_t pc_q   [`INST_BUF_SIZE];
    addr_t npc_q  [`INST_BUF_SIZE];

    buf_idx_t head;
    buf_idx_t tail;
    buf_idx_t count;
    logic push;
    logic pop;

    // wrap bit makes tail - head the occupancy
    assign count = tail - head;
    assign full  = (count == buf_idx_t'(`INST_BUF_SIZE));

    assign dec_valid = (count != '0);
    assign pop       = dec_valid && dec_ready;
    // writes landing on a squash are wrong path
    assign push      = packet_valid && !full && !squash;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + buf_idx_t'(1);
            end
            if (pop) begin
                head <= head + buf_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            inst_q[tail[IDX_W-1:0]] <= packet_inst;
            pc_q[tail[IDX_W-1:0]]   <= packet_pc;
            npc_q[tail[IDX_W-1:0]]  <= packet_npc;
        end
    end

    // head entry is presented to decode
    assign dec_inst = inst_q[head[IDX_W-1:0]];
    assign dec_pc   = pc_q[head[IDX_W-1:0]];
    assign dec_npc  = npc_q[head[IDX_W-1:0]];

endmodule

// ==== hdl/imem.sv ====
// instruction memory model
// 64-bit lines from prog.hex, data valid once the address
// has been held for IMEM_LATENCY cycles

`timescale 1ns/1ps

`include "fetch_defines.svh"

module imem
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t imem_addr,
    output line_t imem_data,
    output logic  imem_data_valid
);

    localparam int LINE_W = $clog2(`IMEM_LINES);
    localparam int CNT_W  = $clog2(`IMEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LATENCY = CNT_W'(`IMEM_LATENCY);

    line_t mem [`IMEM_LINES];

    addr_t last_addr;
    logic addr_changed;
    logic [CNT_W-1:0] stable_cnt;
    logic [CNT_W-1:0] stable_age;

    initial begin
        $readmemh("prog.hex", mem);
    end

    // byte address wraps at IMEM_LINES * 8
    assign imem_data = mem[imem_addr[3 +: LINE_W]];

    // cycles the current address has been present, including this one
    assign addr_changed = (imem_addr != last_addr);
    always_comb begin
        if (addr_changed) begin
            stable_age = CNT_W'(1);
        end else if (stable_cnt >= LATENCY) begin
            stable_age = LATENCY;
        end else begin
            stable_age = stable_cnt + CNT_W'(1);
        end
    end

    assign imem_data_valid = !addr_changed && (stable_age == LATENCY);

    always_ff @(posedge clock) begin
        if (reset) begin
            last_addr  <= '0;
            stable_cnt <= '0;
        end else begin
            last_addr  <= imem_addr;
            stable_cnt <= stable_age;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
// rv_fetch top level
// pc arbiter, fetch FSM, instruction memory and instruction buffer

`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  certain_branch_req,
    input  addr_t certain_branch_pc,
    input  logic  rob_target_req,
    input  addr_t rob_target_pc,
    input  logic  branch_pred_req,
    input  addr_t branch_pred_pc,
    input  logic  dec_ready,
    output logic  dec_valid,
    output inst_t dec_inst,
    output addr_t dec_pc,
    output addr_t dec_npc
);

    addr_t pc;
    addr_t next_pc;
    addr_t imem_addr;
    line_t imem_data;
    logic imem_data_valid;
    logic packet_valid;
    inst_t packet_inst;
    addr_t packet_pc;
    addr_t packet_npc;
    logic squash;
    logic full;

    pc_source_arbiter arbiter_i (
        .certain_branch_req (certain_branch_req),
        .certain_branch_pc  (certain_branch_pc),
        .rob_target_req     (rob_target_req),
        .rob_target_pc      (rob_target_pc),
        .branch_pred_req    (branch_pred_req),
        .branch_pred_pc     (branch_pred_pc),
        .pc                 (pc),
        .grant              (),
        .next_pc            (next_pc)
    );

    ifetch_basic fetch_i (
        .clock              (clock),
        .reset              (reset),
        .full               (full),
        .certain_branch_req (certain_branch_req),
        .certain_branch_pc  (certain_branch_pc),
        .next_pc            (next_pc),
        .imem_data          (imem_data),
        .imem_data_valid    (imem_data_valid),
        .pc                 (pc),
        .imem_addr          (imem_addr),
        .packet_valid       (packet_valid),
        .packet_inst        (packet_inst),
        .packet_pc          (packet_pc),
        .packet_npc         (packet_npc),
        .squash             (squash)
    );

    imem imem_i (
        .clock           (clock),
        .reset           (reset),
        .imem_addr       (imem_addr),
        .imem_data       (imem_data),
        .imem_data_valid (imem_data_valid)
    );

    inst_buffer buffer_i (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .packet_valid (packet_valid),
        .packet_inst  (packet_inst),
        .packet_pc    (packet_pc),
        .packet_npc   (packet_npc),
        .dec_ready    (dec_ready),
        .full         (full),
        .dec_valid    (dec_valid),
        .dec_inst     (dec_inst),
        .dec_pc       (dec_pc),
        .dec_npc      (dec_npc)
    );

endmodule

// ==== testbench/fetch_properties.sv ====
// fetch front end checks
// bound into fetch_top, follows decode output against the memory content
// rule, the expected pc order, redirect priority and buffer overflow

`timescale 1ns/1ps

module fetch_properties
    import fetch_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  certain_branch_req,
    input addr_t certain_branch_pc,
    input logic  rob_target_req,
    input addr_t rob_target_pc,
    input logic  branch_pred_req,
    input addr_t branch_pred_pc,
    input logic  dec_ready,
    input logic  dec_valid,
    input inst_t dec_inst,
    input addr_t dec_pc,
    input addr_t dec_npc,
    input logic  squash,
    input logic  packet_valid,
    input logic  full
);

    // cycles a ROB or lone predictor target may take to reach decode
    localparam int REDIRECT_LIMIT = 30;

    int unsigned fail_count = 0;

    logic  pop;
    inst_t exp_word;
    addr_t exp_npc;
    logic  await_target;
    addr_t target_pc;
    addr_t last_npc;
    logic  jump_ok;
    addr_t rob_seen_pc;
    addr_t pred_seen_pc;
    addr_t shadow_pc;
    logic  redirect_q;
    logic  live_pending;
    addr_t live_pc;
    int unsigned live_age;

    assign pop = dec_valid && dec_ready;
    // word at byte address a is 0x1300_0000 + a/4, memory wraps every 256 bytes
    assign exp_word = 32'h1300_0000 + inst_t'(dec_pc[7:2]);
    assign exp_npc  = dec_pc + addr_t'(4);

    always_ff @(posedge clock) begin
        if (reset) begin
            // first packet after reset comes from pc 0
            await_target <= 1'b1;
            target_pc    <= '0;
            last_npc     <= '0;
            jump_ok      <= 1'b0;
            rob_seen_pc  <= '0;
            pred_seen_pc <= '0;
            // not word aligned, so no fetched pc can match it
            shadow_pc    <= '1;
            redirect_q   <= 1'b0;
            live_pending <= 1'b0;
            live_pc      <= '0;
            live_age     <= 0;
        end else begin
            if (certain_branch_req) begin
                await_target <= 1'b1;
                target_pc    <= certain_branch_pc;
            end else if (pop) begin
                await_target <= 1'b0;
            end
            if (pop) begin
                last_npc <= exp_npc;
            end
            // ROB and predictor jumps stay legal until the next squash
            if (rob_target_req || branch_pred_req) begin
                jump_ok <= 1'b1;
            end else if (certain_branch_req) begin
                jump_ok <= 1'b0;
            end
            if (rob_target_req) begin
                rob_seen_pc <= rob_target_pc;
            end
            if (branch_pred_req && !rob_target_req) begin
                pred_seen_pc <= branch_pred_pc;
            end
            // predictor target that lost to the ROB
            if (branch_pred_req && rob_target_req) begin
                shadow_pc <= branch_pred_pc;
            end
            redirect_q <= rob_target_req || branch_pred_req;
            if (pop && dec_pc == live_pc) begin
                live_pending <= 1'b0;
            end else if ((rob_target_req || branch_pred_req) && !redirect_q) begin
                live_pending <= 1'b1;
                live_pc      <= rob_target_req ? rob_target_pc : branch_pred_pc;
                live_age     <= 0;
            end else if (live_pending) begin
                live_age <= live_age + 1;
            end
        end
    end

    content_check: assert property (@(posedge clock) disable iff (reset)
        dec_valid |-> (dec_inst == exp_word && dec_npc == exp_npc))
        else begin
            fail_count++;
            $error("FAIL packet_content: pc %h expected %h/%h actual %h/%h",
                   $sampled(dec_pc), $sampled(exp_word), $sampled(exp_npc),
                   $sampled(dec_inst), $sampled(dec_npc));
        end

    target_check: assert property (@(posedge clock) disable iff (reset)
        (pop && await_target) |-> dec_pc == target_pc)
        else begin
            fail_count++;
            $error("FAIL redirect_target: expected %h actual %h",
                   $sampled(target_pc), $sampled(dec_pc));
        end

    order_check: assert property (@(posedge clock) disable iff (reset)
        (pop && !await_target) |-> (dec_pc == last_npc
            || (jump_ok && (dec_pc == rob_seen_pc || dec_pc == pred_seen_pc))))
        else begin
            fail_count++;
            $error("FAIL sequential_order: expected %h actual %h",
                   $sampled(last_npc), $sampled(dec_pc));
        end

    hold_check: assert property (@(posedge clock) disable iff (reset)
        (dec_valid && !dec_ready && !squash) |=>
            (dec_valid && $stable(dec_pc) && $stable(dec_inst) && $stable(dec_npc)))
        else begin
            fail_count++;
            $error("decode outputs changed while decode was stalled");
        end

    priority_check: assert property (@(posedge clock) disable iff (reset)
        pop |-> dec_pc != shadow_pc)
        else begin
            fail_count++;
            $error("FAIL source_priority: predictor pc %h reached decode over the ROB",
                   $sampled(dec_pc));
        end

    overflow_check: assert property (@(posedge clock) disable iff (reset)
        (packet_valid && !squash) |-> !full)
        else begin
            fail_count++;
            $error("fetch packet written while the instruction buffer was full");
        end

    redirect_check: assert property (@(posedge clock) disable iff (reset)
        !live_pending || live_age < REDIRECT_LIMIT)
        else begin
            fail_count++;
            $error("redirect target %h did not reach decode in time", $sampled(live_pc));
        end

endmodule

// ==== testbench/fetch_tb.sv ====
// rv_fetch testbench
// steers fetch_top through sequential fetch, back-pressure, squash,
// redirect priority and random decode throttling

`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    // phases take roughly 700 cycles, the rest is margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic  clock;
    logic  reset;
    logic  certain_branch_req;
    addr_t certain_branch_pc;
    logic  rob_target_req;
    addr_t rob_target_pc;
    logic  branch_pred_req;
    addr_t branch_pred_pc;
    logic  dec_ready;
    logic  dec_valid;
    inst_t dec_inst;
    addr_t dec_pc;
    addr_t dec_npc;

    int unsigned cycle_count = 0;
    int unsigned tests_run = 0;
    int unsigned tests_failed = 0;
    int unsigned fails_before = 0;

    fetch_top dut_i (
        .clock              (clock),
        .reset              (reset),
        .certain_branch_req (certain_branch_req),
        .certain_branch_pc  (certain_branch_pc),
        .rob_target_req     (rob_target_req),
        .rob_target_pc      (rob_target_pc),
        .branch_pred_req    (branch_pred_req),
        .branch_pred_pc     (branch_pred_pc),
        .dec_ready          (dec_ready),
        .dec_valid          (dec_valid),
        .dec_inst           (dec_inst),
        .dec_pc             (dec_pc),
        .dec_npc            (dec_npc)
    );

    bind fetch_top fetch_properties props_i (.*);

    initial begin
        clock = 1'b0;
    end

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // word-aligned target within 256 bytes above base
    function automatic addr_t random_target(input addr_t base);
        return base + addr_t'(($urandom % 64) * 4);
    endfunction

    // decode handshakes are counted at the falling edge
    task automatic wait_pops(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clock);
            if (dec_valid && dec_ready) begin
                seen++;
            end
        end
    endtask

    // decode holds off for the branch cycle and the squash cycle after it
    task automatic pulse_branch(input addr_t target, input logic ready_after);
        @(posedge clock);
        certain_branch_req <= 1'b1;
        certain_branch_pc  <= target;
        dec_ready          <= 1'b0;
        @(posedge clock);
        certain_branch_req <= 1'b0;
        @(posedge clock);
        dec_ready <= ready_after;
    endtask

    task automatic finish_test(input string name);
        int unsigned errors;
        errors = dut_i.props_i.fail_count - fails_before;
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
            $display("test %s: %0d check failures", name, errors);
        end else begin
            $display("test %s: ok", name);
        end
        fails_before = dut_i.props_i.fail_count;
    endtask

    initial begin
        void'($urandom(32'haa91));
        reset              = 1'b1;
        certain_branch_req = 1'b0;
        certain_branch_pc  = '0;
        rob_target_req     = 1'b0;
        rob_target_pc      = '0;
        branch_pred_req    = 1'b0;
        branch_pred_pc     = '0;
        dec_ready          = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        wait_pops(12);
        finish_test("sequential_fetch");

        // buffer fills, fetch stalls, then drains in one burst
        @(posedge clock);
        dec_ready <= 1'b0;
        repeat (40) @(posedge clock);
        dec_ready <= 1'b1;
        wait_pops(8);
        finish_test("back_pressure");

        @(posedge clock);
        dec_ready <= 1'b0;
        repeat (12) @(posedge clock);
        pulse_branch(random_target(32'h0), 1'b1);
        wait_pops(6);
        finish_test("branch_squash");

        // targets sit in separate regions away from the sequential stream
        @(posedge clock);
        rob_target_req  <= 1'b1;
        rob_target_pc   <= random_target(32'h1000);
        branch_pred_req <= 1'b1;
        branch_pred_pc  <= random_target(32'h2000);
        repeat (30) @(posedge clock);
        rob_target_req  <= 1'b0;
        branch_pred_req <= 1'b0;
        wait_pops(4);
        finish_test("source_priority");

        @(posedge clock);
        branch_pred_req <= 1'b1;
        branch_pred_pc  <= random_target(32'h3000);
        repeat (30) @(posedge clock);
        branch_pred_req <= 1'b0;
        wait_pops(4);
        finish_test("predictor_redirect");

        repeat (300) begin
            @(posedge clock);
            dec_ready <= (($urandom % 4) != 0);
            if (($urandom % 20) == 0) begin
                pulse_branch(random_target(32'h0), 1'b1);
            end
        end
        @(posedge clock);
        dec_ready <= 1'b1;
        wait_pops(4);
        finish_test("random_throttling");

        @(posedge clock);
        $display("tests %0d, failed %0d, check failures %0d",
                 tests_run, tests_failed, dut_i.props_i.fail_count);
        if (tests_failed == 0 && dut_i.props_i.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== prog.hex ====
// one 64-bit line per row: upper word at byte offset 4, lower word at byte offset 0
1300000113000000
1300000313000002
1300000513000004
1300000713000006
1300000913000008
1300000B1300000A
1300000D1300000C
1300000F1300000E
1300001113000010
1300001313000012
1300001513000014
1300001713000016
1300001913000018
1300001B1300001A
1300001D1300001C
1300001F1300001E
1300002113000020
1300002313000022
1300002513000024
1300002713000026
1300002913000028
1300002B1300002A
1300002D1300002C
1300002F1300002E
1300003113000030
1300003313000032
1300003513000034
1300003713000036
1300003913000038
1300003B1300003A
1300003D1300003C
1300003F1300003E

// ==== rv_fetch.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/pc_source_arbiter.sv
hdl/ifetch_basic.sv
hdl/inst_buffer.sv
hdl/imem.sv
hdl/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rv_fetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/pc_source_arbiter.sv
      - hdl/ifetch_basic.sv
      - hdl/inst_buffer.sv
      - hdl/imem.sv
      - hdl/fetch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/fetch_properties.sv
      - testbench/fetch_tb.sv
